// ==== all.f ====
src/cache_pkg.sv
src/cache_store.sv
src/access_fsm.sv
src/line_fill.sv
src/write_buffer.sv
src/cache_stats.sv
src/memory_cache.sv
tests/tb_memory_cache.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_memory_cache -f all.f --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
   echo "run.sh: verilator build failed"
   exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
   echo "run.sh: simulation exited with status $sim_status"
   exit 1
fi

if grep -qx "Simulation finished: PASS" sim.log; then
   exit 0
fi
echo "run.sh: pass line not found in sim.log"
exit 1

// ==== src/access_fsm.sv ====
`timescale 1ns/1ps

module access_fsm
   import cache_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        cpu_req,
   input  strb_t       cpu_wstrb,
   input  logic        hit,
   input  logic        buffer_full,
   input  logic        buffer_empty,
   input  logic        fill_busy,
   output logic        cpu_ack,
   output logic        store_write_en,
   output logic        fill_start,
   output logic        buffer_push,
   output stat_event_t event_code
);

   typedef enum logic [2:0] {
      st_idle,
      st_write_check,
      st_read_check,
      st_fill_wait,
      st_read_settle,
      st_end,
      st_delay
   } state_t;

   state_t state;
   state_t next_state;

   always_comb
   begin
      next_state     = state;
      store_write_en = 1'b0;
      fill_start     = 1'b0;
      buffer_push    = 1'b0;
      event_code     = ev_none;
      case (state)
         st_idle:
         begin
            if (cpu_req && (|cpu_wstrb))
               next_state = st_write_check;
            else if (cpu_req)
               next_state = st_read_check;
         end
         st_write_check:
         begin
            if (!buffer_full)                         // stall while the FIFO is full
            begin
               buffer_push    = 1'b1;
               store_write_en = hit;                  // no allocate on a write miss
               event_code     = hit ? ev_write_hit : ev_write_miss;
               next_state     = st_end;
            end
         end
         st_read_check:
         begin
            if (buffer_empty)                         // memory must hold all earlier writes
            begin
               if (hit)
               begin
                  event_code = ev_read_hit;
                  next_state = st_read_settle;
               end
               else
               begin
                  event_code = ev_read_miss;
                  fill_start = 1'b1;
                  next_state = st_fill_wait;
               end
            end
         end
         st_fill_wait:
         begin
            if (!fill_busy)
               next_state = st_read_settle;           // re-read the freshly filled line
         end
         st_read_settle:
            next_state = st_end;
         st_end:
            next_state = st_delay;
         default:
            next_state = st_idle;                     // delay cycle drops the held request
      endcase
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         state   <= st_idle;
         cpu_ack <= 1'b0;
      end
      else
      begin
         state   <= next_state;
         cpu_ack <= (state == st_end);                // high during the delay cycle
      end
   end

endmodule

// ==== src/cache_pkg.sv ====
package cache_pkg;

   localparam int ADDR_W      = 32;
   localparam int DATA_W      = 32;
   localparam int N_BYTES     = DATA_W / 8;                        // strobe width
   localparam int INDEX_W     = 3;                                 // 8 lines
   localparam int OFFSET_W    = 3;                                 // 8 words per line
   localparam int TAG_W       = ADDR_W - INDEX_W - OFFSET_W - 2;   // two byte bits dropped
   localparam int BUFFER_W    = 4;                                 // 16 write entries
   localparam int CTRL_ADDR_W = 4;

   // line fill burst, one beat per word of the line
   localparam logic [7:0] BURST_LEN  = 8'd7;
   localparam logic [2:0] BURST_SIZE = 3'd2;    // 4 bytes per beat
   localparam logic [1:0] BURST_INCR = 2'b01;

   typedef logic [ADDR_W-1:0]   addr_t;
   typedef logic [DATA_W-1:0]   word_t;
   typedef logic [N_BYTES-1:0]  strb_t;
   typedef logic [INDEX_W-1:0]  index_t;
   typedef logic [OFFSET_W-1:0] offset_t;
   typedef logic [TAG_W-1:0]    tag_t;

   typedef enum logic [2:0] {
      ev_none,
      ev_read_hit,
      ev_read_miss,
      ev_write_hit,
      ev_write_miss
   } stat_event_t;

   // control port addresses
   localparam logic [CTRL_ADDR_W-1:0] ca_hit_total      = 4'd0;
   localparam logic [CTRL_ADDR_W-1:0] ca_miss_total     = 4'd1;
   localparam logic [CTRL_ADDR_W-1:0] ca_read_hit       = 4'd2;
   localparam logic [CTRL_ADDR_W-1:0] ca_read_miss      = 4'd3;
   localparam logic [CTRL_ADDR_W-1:0] ca_write_hit      = 4'd4;
   localparam logic [CTRL_ADDR_W-1:0] ca_write_miss     = 4'd5;
   localparam logic [CTRL_ADDR_W-1:0] ca_reset_counters = 4'd6;
   localparam logic [CTRL_ADDR_W-1:0] ca_invalidate     = 4'd7;

endpackage

// ==== src/cache_stats.sv ====
`timescale 1ns/1ps

module cache_stats
   import cache_pkg::*;
(
   input  logic                   clk,
   input  logic                   reset,
   input  stat_event_t            event_code,
   input  logic                   ctrl_req,
   input  logic [CTRL_ADDR_W-1:0] ctrl_addr,
   output logic                   ctrl_ack,
   output word_t                  ctrl_rdata,
   output logic                   invalidate
);

   word_t read_hit_cnt;
   word_t read_miss_cnt;
   word_t write_hit_cnt;
   word_t write_miss_cnt;
   word_t hit_total;
   word_t miss_total;
   logic  clear_cnt;

   assign hit_total  = read_hit_cnt + write_hit_cnt;
   assign miss_total = read_miss_cnt + write_miss_cnt;
   assign clear_cnt  = ctrl_req && (ctrl_addr == ca_reset_counters);

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         read_hit_cnt   <= '0;
         read_miss_cnt  <= '0;
         write_hit_cnt  <= '0;
         write_miss_cnt <= '0;
      end
      else if (clear_cnt)
      begin
         read_hit_cnt   <= '0;                        // zero from the next cycle on
         read_miss_cnt  <= '0;
         write_hit_cnt  <= '0;
         write_miss_cnt <= '0;
      end
      else
      begin
         case (event_code)
            ev_read_hit:   read_hit_cnt   <= read_hit_cnt + 1'b1;
            ev_read_miss:  read_miss_cnt  <= read_miss_cnt + 1'b1;
            ev_write_hit:  write_hit_cnt  <= write_hit_cnt + 1'b1;
            ev_write_miss: write_miss_cnt <= write_miss_cnt + 1'b1;
            default:       ;
         endcase
      end
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         ctrl_ack   <= 1'b0;
         invalidate <= 1'b0;
      end
      else
      begin
         ctrl_ack   <= ctrl_req;                      // answer one cycle after the strobe
         invalidate <= ctrl_req && (ctrl_addr == ca_invalidate);
      end
   end

   always_ff @(posedge clk)
   begin
      ctrl_rdata <= '0;
      if (ctrl_req)
      begin
         case (ctrl_addr)
            ca_hit_total:  ctrl_rdata <= hit_total;
            ca_miss_total: ctrl_rdata <= miss_total;
            ca_read_hit:   ctrl_rdata <= read_hit_cnt;
            ca_read_miss:  ctrl_rdata <= read_miss_cnt;
            ca_write_hit:  ctrl_rdata <= write_hit_cnt;
            ca_write_miss: ctrl_rdata <= write_miss_cnt;
            default:       ctrl_rdata <= '0;
         endcase
      end
   end

endmodule

// ==== src/cache_store.sv ====
`timescale 1ns/1ps

module cache_store
   import cache_pkg::*;
(
   input  logic    clk,
   input  logic    reset,
   input  logic    invalidate,
   input  addr_t   addr,
   input  word_t   cpu_wdata,
   input  strb_t   cpu_wstrb,
   input  logic    store_write_en,
   input  logic    fill_we,
   input  offset_t fill_offset,
   input  word_t   fill_data,
   input  logic    fill_done_we,
   output logic    hit,
   output word_t   rdata
);

   word_t                   line_data [2**INDEX_W][2**OFFSET_W];
   tag_t                    tag_mem [2**INDEX_W];
   logic [2**INDEX_W-1:0]   valid;
   index_t                  index;
   offset_t                 offset;
   tag_t                    tag;

   assign index  = addr[OFFSET_W+2 +: INDEX_W];
   assign offset = addr[2 +: OFFSET_W];
   assign tag    = addr[ADDR_W-1 -: TAG_W];

   assign hit = valid[index] && (tag_mem[index] == tag);

   // fill beats take the whole word, cpu writes only the strobed bytes
   always_ff @(posedge clk)
   begin
      if (fill_we)
         line_data[index][fill_offset] <= fill_data;
      else if (store_write_en)
         for (int b = 0; b < N_BYTES; b++)
            if (cpu_wstrb[b])
               line_data[index][offset][8*b +: 8] <= cpu_wdata[8*b +: 8];
      if (fill_done_we)
         tag_mem[index] <= tag;
      rdata <= line_data[index][offset];              // addressed word, every cycle
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         valid <= '0;
      else if (invalidate)
         valid <= '0;                                  // flush the whole cache
      else if (fill_done_we)
         valid[index] <= 1'b1;
   end

endmodule

// ==== src/line_fill.sv ====
`timescale 1ns/1ps

module line_fill
   import cache_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  logic       fill_start,
   input  addr_t      addr,
   output logic       fill_busy,
   output logic       fill_we,
   output logic       fill_done_we,
   output offset_t    fill_offset,
   output word_t      fill_data,
   output addr_t      AR_ADDR,
   output logic [7:0] AR_LEN,
   output logic [2:0] AR_SIZE,
   output logic [1:0] AR_BURST,
   output logic       AR_VALID,
   input  logic       AR_READY,
   input  logic       R_VALID,
   output logic       R_READY,
   input  word_t      R_DATA,
   input  logic       R_LAST
);

   typedef enum logic [1:0] {st_idle, st_addr, st_data} state_t;

   state_t  state;
   offset_t beat;
   logic    beat_valid;

   assign AR_LEN   = BURST_LEN;
   assign AR_SIZE  = BURST_SIZE;
   assign AR_BURST = BURST_INCR;
   assign AR_VALID = (state == st_addr);
   assign R_READY  = (state == st_data);
   assign fill_busy = (state != st_idle);

   assign beat_valid   = R_VALID && R_READY;
   assign fill_we      = beat_valid;
   assign fill_done_we = beat_valid && R_LAST;         // tag and valid with the last word
   assign fill_data    = R_DATA;
   assign fill_offset  = beat;

   always_ff @(posedge clk)
   begin
      if (fill_start)
         AR_ADDR <= {addr[ADDR_W-1:OFFSET_W+2], {(OFFSET_W+2){1'b0}}};   // line aligned
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         state <= st_idle;
         beat  <= '0;
      end
      else
      begin
         case (state)
            st_idle:
            begin
               beat <= '0;
               if (fill_start)
                  state <= st_addr;
            end
            st_addr:
            begin
               if (AR_READY)
                  state <= st_data;
            end
            default:
            begin
               if (beat_valid)
               begin
                  beat <= beat + 1'b1;
                  if (R_LAST)
                     state <= st_idle;
               end
            end
         endcase
      end
   end

endmodule

// ==== src/memory_cache.sv ====
`timescale 1ns/1ps

module memory_cache
   import cache_pkg::*;
(
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   cpu_req,
   input  addr_t                  cpu_addr,
   input  word_t                  cpu_wdata,
   input  strb_t                  cpu_wstrb,
   output word_t                  cpu_rdata,
   output logic                   cpu_ack,
   output logic                   buffer_clear,
   input  logic                   ctrl_req,
   input  logic [CTRL_ADDR_W-1:0] ctrl_addr,
   output word_t                  ctrl_rdata,
   output logic                   ctrl_ack,
   output addr_t                  AR_ADDR,
   output logic [7:0]             AR_LEN,
   output logic [2:0]             AR_SIZE,
   output logic [1:0]             AR_BURST,
   output logic                   AR_VALID,
   input  logic                   AR_READY,
   input  logic                   R_VALID,
   output logic                   R_READY,
   input  word_t                  R_DATA,
   input  logic                   R_LAST,
   output addr_t                  AW_ADDR,
   output logic                   AW_VALID,
   input  logic                   AW_READY,
   output word_t                  W_DATA,
   output strb_t                  W_STRB,
   output logic                   W_VALID,
   input  logic                   W_READY,
   input  logic                   B_VALID,
   output logic                   B_READY
);

   logic        hit;
   logic        store_write_en;
   logic        fill_start;
   logic        fill_busy;
   logic        fill_we;
   logic        fill_done_we;
   offset_t     fill_offset;
   word_t       fill_data;
   logic        buffer_push;
   logic        buffer_full;
   logic        buffer_empty;
   logic        invalidate;
   stat_event_t event_code;

   assign buffer_clear = buffer_empty;                 // all writes answered by memory

   access_fsm i_access_fsm (
      .clk(clk), .reset(reset), .cpu_req(cpu_req), .cpu_wstrb(cpu_wstrb), .hit(hit),
      .buffer_full(buffer_full), .buffer_empty(buffer_empty), .fill_busy(fill_busy),
      .cpu_ack(cpu_ack), .store_write_en(store_write_en), .fill_start(fill_start),
      .buffer_push(buffer_push), .event_code(event_code)
   );

   cache_store i_cache_store (
      .clk(clk), .reset(reset), .invalidate(invalidate), .addr(cpu_addr),
      .cpu_wdata(cpu_wdata), .cpu_wstrb(cpu_wstrb), .store_write_en(store_write_en),
      .fill_we(fill_we), .fill_offset(fill_offset), .fill_data(fill_data),
      .fill_done_we(fill_done_we), .hit(hit), .rdata(cpu_rdata)
   );

   line_fill i_line_fill (
      .clk(clk), .reset(reset), .fill_start(fill_start), .addr(cpu_addr),
      .fill_busy(fill_busy), .fill_we(fill_we), .fill_done_we(fill_done_we),
      .fill_offset(fill_offset), .fill_data(fill_data), .AR_ADDR(AR_ADDR), .AR_LEN(AR_LEN),
      .AR_SIZE(AR_SIZE), .AR_BURST(AR_BURST), .AR_VALID(AR_VALID), .AR_READY(AR_READY),
      .R_VALID(R_VALID), .R_READY(R_READY), .R_DATA(R_DATA), .R_LAST(R_LAST)
   );

   write_buffer i_write_buffer (
      .clk(clk), .reset(reset), .buffer_push(buffer_push), .addr(cpu_addr),
      .wdata(cpu_wdata), .wstrb(cpu_wstrb), .buffer_full(buffer_full),
      .buffer_empty(buffer_empty), .AW_ADDR(AW_ADDR), .AW_VALID(AW_VALID),
      .AW_READY(AW_READY), .W_DATA(W_DATA), .W_STRB(W_STRB), .W_VALID(W_VALID),
      .W_READY(W_READY), .B_VALID(B_VALID), .B_READY(B_READY)
   );

   cache_stats i_cache_stats (
      .clk(clk), .reset(reset), .event_code(event_code), .ctrl_req(ctrl_req),
      .ctrl_addr(ctrl_addr), .ctrl_ack(ctrl_ack), .ctrl_rdata(ctrl_rdata),
      .invalidate(invalidate)
   );

endmodule

// ==== src/write_buffer.sv ====
`timescale 1ns/1ps

module write_buffer
   import cache_pkg::*;
(
   input  logic  clk,
   input  logic  reset,
   input  logic  buffer_push,
   input  addr_t addr,
   input  word_t wdata,
   input  strb_t wstrb,
   output logic  buffer_full,
   output logic  buffer_empty,
   output addr_t AW_ADDR,
   output logic  AW_VALID,
   input  logic  AW_READY,
   output word_t W_DATA,
   output strb_t W_STRB,
   output logic  W_VALID,
   input  logic  W_READY,
   input  logic  B_VALID,
   output logic  B_READY
);

   typedef enum logic [1:0] {st_idle, st_aw, st_w, st_b} state_t;

   logic [ADDR_W-3:0] fifo_addr [2**BUFFER_W];         // word address, byte bits dropped
   word_t             fifo_data [2**BUFFER_W];
   strb_t             fifo_strb [2**BUFFER_W];
   logic [BUFFER_W:0] wr_ptr;
   logic [BUFFER_W:0] rd_ptr;
   logic              pop;
   state_t            state;

   assign buffer_empty = (wr_ptr == rd_ptr);
   assign buffer_full  = (wr_ptr[BUFFER_W] != rd_ptr[BUFFER_W]) &&
                         (wr_ptr[BUFFER_W-1:0] == rd_ptr[BUFFER_W-1:0]);

   // head entry stays in place until its response arrives
   assign AW_ADDR = {fifo_addr[rd_ptr[BUFFER_W-1:0]], 2'b00};
   assign W_DATA  = fifo_data[rd_ptr[BUFFER_W-1:0]];
   assign W_STRB  = fifo_strb[rd_ptr[BUFFER_W-1:0]];

   assign AW_VALID = (state == st_aw);
   assign W_VALID  = (state == st_w);
   assign B_READY  = (state == st_b);
   assign pop      = B_VALID && B_READY;

   always_ff @(posedge clk)
   begin
      if (buffer_push)
      begin
         fifo_addr[wr_ptr[BUFFER_W-1:0]] <= addr[ADDR_W-1:2];
         fifo_data[wr_ptr[BUFFER_W-1:0]] <= wdata;
         fifo_strb[wr_ptr[BUFFER_W-1:0]] <= wstrb;
      end
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         state  <= st_idle;
      end
      else
      begin
         if (buffer_push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;                  // empty only once memory has answered
         case (state)
            st_idle:
               if (!buffer_empty)
                  state <= st_aw;
            st_aw:
               if (AW_READY)
                  state <= st_w;
            st_w:
               if (W_READY)
                  state <= st_b;
            default:
               if (B_VALID)
                  state <= st_idle;
         endcase
      end
   end

endmodule

// ==== tests/tb_memory_cache.sv ====
`timescale 1ns/1ps

module tb_memory_cache
   import cache_pkg::*;
();

   localparam int N_RANDOM = 96;
   localparam int N_OPS    = N_RANDOM + 24;           // random accesses plus directed ones

   logic                   clk;
   logic                   reset;
   logic                   cpu_req;
   addr_t                  cpu_addr;
   word_t                  cpu_wdata;
   strb_t                  cpu_wstrb;
   word_t                  cpu_rdata;
   logic                   cpu_ack;
   logic                   buffer_clear;
   logic                   ctrl_req;
   logic [CTRL_ADDR_W-1:0] ctrl_addr;
   word_t                  ctrl_rdata;
   logic                   ctrl_ack;
   addr_t                  AR_ADDR;
   logic [7:0]             AR_LEN;
   logic [2:0]             AR_SIZE;
   logic [1:0]             AR_BURST;
   logic                   AR_VALID;
   logic                   AR_READY;
   logic                   R_VALID;
   logic                   R_READY;
   word_t                  R_DATA;
   logic                   R_LAST;
   addr_t                  AW_ADDR;
   logic                   AW_VALID;
   logic                   AW_READY;
   word_t                  W_DATA;
   strb_t                  W_STRB;
   logic                   W_VALID;
   logic                   W_READY;
   logic                   B_VALID;
   logic                   B_READY;

   logic [7:0] mem_bytes [addr_t];                    // only bytes written so far
   addr_t      exp_addr [$];                          // writes still owed on AXI
   word_t      exp_data [$];
   strb_t      exp_strb [$];
   logic       line_valid [2**INDEX_W];               // what the cache should hold
   tag_t       line_tag [2**INDEX_W];
   int         rd_hits;
   int         rd_misses;
   int         wr_hits;
   int         wr_misses;
   int         ar_expected;
   int         ar_seen;
   addr_t      expect_ar_addr;

   memory_cache i_memory_cache (.*);

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   initial
   begin
      repeat (N_OPS * 200) @(posedge clk);
      $display("ERROR at %0t: watchdog expired before the tests completed", $time);
      $display("Simulation finished: FAIL");
      $fatal(1, "watchdog expired");
   end

   task automatic report_mismatch(input string name, input word_t expected, input word_t actual);
      $display("FAIL at %0t: %s expected %h, got %h", $time, name, expected, actual);
      $display("Simulation finished: FAIL");
      $fatal(1, "value mismatch");
   endtask

   task automatic report_error(input string what);
      $display("ERROR at %0t: %s", $time, what);
      $display("Simulation finished: FAIL");
      $fatal(1, "check failed");
   endtask

   ack_single: assert property (@(posedge clk) disable iff (reset) cpu_ack |=> !cpu_ack)
      else report_error("cpu_ack stayed high for two cycles");
   ctrl_answer: assert property (@(posedge clk) disable iff (reset) ctrl_req |=> ctrl_ack)
      else report_error("ctrl_ack did not follow ctrl_req by one cycle");

   // background memory contents, spread over the whole address
   function automatic logic [7:0] fill_byte(input addr_t a);
      logic [31:0] h;
      h = a * 32'h9E37_79B1;
      return h[31:24];
   endfunction

   function automatic word_t mem_word(input addr_t a);
      word_t w;
      addr_t x;
      for (int b = 0; b < N_BYTES; b++)
      begin
         x = {a[ADDR_W-1:2], 2'b00} + b;
         w[8*b +: 8] = mem_bytes.exists(x) ? mem_bytes[x] : fill_byte(x);
      end
      return w;
   endfunction

   // two tags share each index, so lines evict each other
   function automatic addr_t random_addr();
      addr_t a;
      a = 32'h0000_1000;
      if ($urandom_range(0, 1) == 1)
         a = a + 32'h0000_1000;
      if ($urandom_range(0, 1) == 1)
         a = a + 32'h0000_0020;
      return a + 4 * $urandom_range(0, 7);
   endfunction

   task automatic gap_cycles(input int unsigned n);
      repeat (n)
      begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic cpu_access(input addr_t a, input word_t d, input strb_t s);
      index_t idx;
      tag_t   tg;
      logic   is_hit;
      idx    = a[OFFSET_W+2 +: INDEX_W];
      tg     = a[ADDR_W-1 -: TAG_W];
      is_hit = line_valid[idx] && (line_tag[idx] == tg);
      if (s != '0)
      begin
         if (is_hit)
            wr_hits++;
         else
            wr_misses++;                              // no allocate
         exp_addr.push_back({a[ADDR_W-1:2], 2'b00});
         exp_data.push_back(d);
         exp_strb.push_back(s);
      end
      else if (is_hit)
         rd_hits++;
      else
      begin
         rd_misses++;
         ar_expected++;
         expect_ar_addr = a - a % addr_t'(4 * 2**OFFSET_W);   // start of the line
         line_valid[idx] = 1'b1;
         line_tag[idx]   = tg;
      end
      cpu_addr  = a;
      cpu_wdata = d;
      cpu_wstrb = s;
      cpu_req   = 1'b1;
      do @(posedge clk); while (!cpu_ack);
      if (s == '0)
      begin
         assert (cpu_rdata == mem_word(a))
            else report_mismatch("cpu_rdata", mem_word(a), cpu_rdata);
      end
      assert (ar_seen == ar_expected)
         else report_mismatch("AR burst count", word_t'(ar_expected), word_t'(ar_seen));
      #1 cpu_req = 1'b0;
      cpu_wstrb = '0;
   endtask

   task automatic ctrl_command(input logic [CTRL_ADDR_W-1:0] code, input word_t expected);
      ctrl_req  = 1'b1;
      ctrl_addr = code;
      @(posedge clk);
      #1 ctrl_req = 1'b0;
      @(posedge clk);
      assert (ctrl_ack) else report_error("ctrl_ack missing after a control request");
      assert (ctrl_rdata == expected)
         else report_mismatch($sformatf("ctrl_rdata code %0d", code), expected, ctrl_rdata);
      #1;
   endtask

   task automatic check_counters();
      ctrl_command(ca_hit_total, word_t'(rd_hits + wr_hits));
      ctrl_command(ca_miss_total, word_t'(rd_misses + wr_misses));
      ctrl_command(ca_read_hit, word_t'(rd_hits));
      ctrl_command(ca_read_miss, word_t'(rd_misses));
      ctrl_command(ca_write_hit, word_t'(wr_hits));
      ctrl_command(ca_write_miss, word_t'(wr_misses));
   endtask

   initial
   begin : read_slave
      addr_t line;
      AR_READY = 1'b0;
      R_VALID  = 1'b0;
      R_LAST   = 1'b0;
      R_DATA   = '0;
      forever
      begin
         do @(posedge clk); while (AR_VALID !== 1'b1);
         #1;
         gap_cycles($urandom_range(0, 3));
         AR_READY = 1'b1;
         @(posedge clk);
         line = AR_ADDR;
         ar_seen++;
         assert (AR_ADDR == expect_ar_addr)
            else report_mismatch("AR_ADDR", expect_ar_addr, AR_ADDR);
         assert (AR_LEN == 8'd7) else report_mismatch("AR_LEN", 32'd7, word_t'(AR_LEN));
         assert (AR_SIZE == 3'd2) else report_mismatch("AR_SIZE", 32'd2, word_t'(AR_SIZE));
         assert (AR_BURST == 2'd1) else report_mismatch("AR_BURST", 32'd1, word_t'(AR_BURST));
         #1 AR_READY = 1'b0;
         for (int beat = 0; beat < 2**OFFSET_W; beat++)
         begin
            gap_cycles($urandom_range(0, 3));
            R_VALID = 1'b1;
            R_DATA  = mem_word(line + 4 * beat);
            R_LAST  = (beat == 2**OFFSET_W - 1);
            do @(posedge clk); while (!R_READY);
            #1 R_VALID = 1'b0;
            R_LAST = 1'b0;
         end
      end
   end

   initial
   begin : write_slave
      addr_t aw;
      word_t wd;
      strb_t ws;
      AW_READY = 1'b0;
      W_READY  = 1'b0;
      B_VALID  = 1'b0;
      forever
      begin
         do @(posedge clk); while (AW_VALID !== 1'b1);
         #1;
         gap_cycles($urandom_range(0, 3));
         AW_READY = 1'b1;
         @(posedge clk);
         aw = AW_ADDR;
         #1 AW_READY = 1'b0;
         gap_cycles($urandom_range(0, 3));
         W_READY = 1'b1;
         do @(posedge clk); while (!W_VALID);
         wd = W_DATA;
         ws = W_STRB;
         #1 W_READY = 1'b0;
         gap_cycles($urandom_range(0, 3));
         B_VALID = 1'b1;
         do @(posedge clk); while (!B_READY);
         assert (exp_addr.size() != 0) else report_error("AXI write with no CPU write pending");
         assert (aw == exp_addr[0]) else report_mismatch("AW_ADDR", exp_addr[0], aw);
         assert (wd == exp_data[0]) else report_mismatch("W_DATA", exp_data[0], wd);
         assert (ws == exp_strb[0])
            else report_mismatch("W_STRB", word_t'(exp_strb[0]), word_t'(ws));
         void'(exp_addr.pop_front());
         void'(exp_data.pop_front());
         void'(exp_strb.pop_front());
         for (int b = 0; b < N_BYTES; b++)
            if (ws[b])
               mem_bytes[aw + b] = wd[8*b +: 8];      // memory changes with the response
         #1 B_VALID = 1'b0;
      end
   end

   initial
   begin : stimulus
      void'($urandom(92990));
      reset     = 1'b1;
      cpu_req   = 1'b0;
      cpu_addr  = '0;
      cpu_wdata = '0;
      cpu_wstrb = '0;
      ctrl_req  = 1'b0;
      ctrl_addr = '0;
      rd_hits = 0;
      rd_misses = 0;
      wr_hits = 0;
      wr_misses = 0;
      ar_expected = 0;
      ar_seen = 0;
      expect_ar_addr = '0;
      for (int i = 0; i < 2**INDEX_W; i++)
         line_valid[i] = 1'b0;
      repeat (10) @(posedge clk);
      #1 reset = 1'b0;
      assert (buffer_clear) else report_error("buffer_clear low after reset");

      for (int i = 0; i < N_RANDOM; i++)
      begin
         if ($urandom_range(0, 1) == 1)
            cpu_access(random_addr(), $urandom(), strb_t'($urandom_range(1, 15)));
         else
            cpu_access(random_addr(), '0, '0);
      end
      check_counters();

      cpu_access(32'h0000_1004, '0, '0);              // make sure the line is cached
      ctrl_command(ca_invalidate, '0);
      for (int i = 0; i < 2**INDEX_W; i++)
         line_valid[i] = 1'b0;
      cpu_access(32'h0000_1004, '0, '0);              // refetch after the flush
      cpu_access(32'h0000_1008, '0, '0);
      check_counters();

      ctrl_command(ca_reset_counters, '0);
      rd_hits = 0;
      rd_misses = 0;
      wr_hits = 0;
      wr_misses = 0;
      check_counters();

      cpu_access(32'h0000_1010, 32'hA5A5_5A5A, 4'b1111);   // leave writes in flight
      cpu_access(32'h0000_2024, 32'h1234_5678, 4'b0101);
      while (exp_addr.size() != 0)
         @(posedge clk);
      @(posedge clk);
      assert (buffer_clear) else report_error("buffer_clear low after all writes were answered");
      $display("Simulation finished: PASS");
      $finish;
   end

endmodule
